//--- blur_engine.sv
`timescale 1ns/1ps
`include "kp_macros.svh"

module blur_engine (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             go,
    output logic             fin,
    output kp_pkg::ram_req_t img_req,
    input  kp_pkg::pixel_t   img_dout,
    output kp_pkg::ram_req_t blr_req
);
    import kp_pkg::*;

    logic       busy;
    coord_t     row, col;
    logic [1:0] tr, tc;          // tap offset plus one
    logic [4:0] nr, nc;          // neighbour coords, -1 wraps to 31
    logic       tap_ok;
    logic [1:0] tap_w;

    logic       v_d;
    logic       tap_ok_d;
    logic [1:0] tap_w_d;
    logic       first_d, last_d;
    pix_addr_t  addr_d;

    logic [11:0] weighted;
    logic [11:0] acc;            // 16 * 255 fits
    logic        wr_pend;
    pix_addr_t   wr_addr;

    always_comb begin
        nr     = {1'b0, row} + {3'b000, tr} - 5'd1;
        nc     = {1'b0, col} + {3'b000, tc} - 5'd1;
        tap_ok = (nr < 5'(`KP_IMG_DIM)) && (nc < 5'(`KP_IMG_DIM));
        tap_w  = 2'(tr == 2'd1) + 2'(tc == 2'd1);  // corner 1, edge 2, centre 4
        img_req.we   = 1'b0;
        img_req.addr = {nr[3:0], nc[3:0]};
        img_req.din  = '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            row  <= '0;
            col  <= '0;
            tr   <= '0;
            tc   <= '0;
        end else if (go) begin
            busy <= 1'b1;
            row  <= '0;
            col  <= '0;
            tr   <= '0;
            tc   <= '0;
        end else if (busy) begin
            if (tc == 2'd2) begin
                tc <= '0;
                if (tr == 2'd2) begin
                    tr  <= '0;
                    col <= col + 1'b1;
                    if (col == coord_t'(`KP_IMG_DIM - 1)) begin
                        row <= row + 1'b1;
                        if (row == coord_t'(`KP_IMG_DIM - 1)) begin
                            busy <= 1'b0;
                        end
                    end
                end else begin
                    tr <= tr + 1'b1;
                end
            end else begin
                tc <= tc + 1'b1;
            end
        end
    end

    // tap info lines up with the read data
    always_ff @(posedge clk) begin
        tap_ok_d <= tap_ok;
        tap_w_d  <= tap_w;
        first_d  <= (tr == 2'd0) && (tc == 2'd0);
        last_d   <= (tr == 2'd2) && (tc == 2'd2);
        addr_d   <= {row, col};
    end

    assign weighted = tap_ok_d ? (12'(img_dout) << tap_w_d) : '0;  // border is zero

    always_ff @(posedge clk) begin
        if (v_d) begin
            acc <= first_d ? weighted : acc + weighted;
        end
        if (v_d && last_d) begin
            wr_addr <= addr_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v_d     <= 1'b0;
            wr_pend <= 1'b0;
            fin     <= 1'b0;
        end else begin
            v_d     <= busy;
            wr_pend <= v_d && last_d;
            fin     <= wr_pend && (wr_addr == pix_addr_t'(`KP_NUM_PIX - 1));
        end
    end

    assign blr_req.we   = wr_pend;
    assign blr_req.addr = wr_addr;
    assign blr_req.din  = pixel_t'(acc >> `KP_BLUR_SHIFT);

    // only the last pixel's write may trail the end of the scan
    a_no_idle_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        blr_req.we && !busy |-> blr_req.addr == pix_addr_t'(`KP_NUM_PIX - 1)
    );

endmodule

//--- keypoint_detect.sv
`timescale 1ns/1ps
`include "kp_macros.svh"

module keypoint_detect (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             go,
    output logic             fin,
    input  logic             filter_on,
    input  kp_pkg::thresh_t  threshold,
    output kp_pkg::ram_req_t img_req,
    output kp_pkg::ram_req_t blr_req,
    input  kp_pkg::pixel_t   img_dout,
    input  kp_pkg::pixel_t   blr_dout,
    output logic             kpt_wr,
    output kp_pkg::kpt_t     kpt_wr_data
);
    import kp_pkg::*;

    logic              busy;
    pix_addr_t         addr;
    logic              v1, v2;
    pix_addr_t         addr1, addr2;
    logic              hit2;
    logic signed [9:0] diff, limit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            addr <= '0;
        end else if (go) begin
            busy <= 1'b1;
            addr <= '0;
        end else if (busy) begin
            addr <= addr + 1'b1;
            if (addr == pix_addr_t'(`KP_NUM_PIX - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    assign img_req = '{we: 1'b0, addr: addr, din: '0};
    assign blr_req = '{we: 1'b0, addr: addr, din: '0};

    always_comb begin
        diff  = $signed({2'b00, img_dout}) - $signed({2'b00, blr_dout});
        limit = filter_on ? $signed({2'b00, threshold}) : 10'sd0;
    end

    always_ff @(posedge clk) begin
        addr1 <= addr;
        addr2 <= addr1;
        hit2  <= diff > limit;  // data of addr1 is on dout
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v1  <= 1'b0;
            v2  <= 1'b0;
            fin <= 1'b0;
        end else begin
            v1  <= busy;
            v2  <= v1;
            fin <= v2 && (addr2 == pix_addr_t'(`KP_NUM_PIX - 1));
        end
    end

    assign kpt_wr      = v2 && hit2;
    assign kpt_wr_data = '{row: addr2[7:4], col: addr2[3:0]};

endmodule

//--- keypoint_store.sv
`timescale 1ns/1ps
`include "kp_macros.svh"

module keypoint_store (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               run_clear,
    input  logic               kpt_wr,
    input  kp_pkg::kpt_t       kpt_wr_data,
    input  kp_pkg::pix_addr_t  kpt_rd_addr,
    output kp_pkg::kpt_t       kpt_rd_data,
    output kp_pkg::kpt_count_t kpt_count
);
    import kp_pkg::*;

    kpt_t mem [`KP_KPT_DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kpt_count <= '0;
        end else if (run_clear) begin
            kpt_count <= '0;
        end else if (kpt_wr) begin
            kpt_count <= kpt_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (kpt_wr) begin
            mem[pix_addr_t'(kpt_count)] <= kpt_wr_data;  // next free slot
        end
        kpt_rd_data <= mem[kpt_rd_addr];
    end

    // one image can not yield more keypoints than slots
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        kpt_wr |-> kpt_count != kpt_count_t'(`KP_KPT_DEPTH)
    );

endmodule

//--- kp_core.sv
`timescale 1ns/1ps

module kp_core (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    output logic               done,
    input  logic               img_we,
    input  kp_pkg::pix_addr_t  img_addr,
    input  kp_pkg::pixel_t     img_din,
    input  logic               filter_on,
    input  kp_pkg::thresh_t    threshold,
    input  kp_pkg::pix_addr_t  kpt_rd_addr,
    output kp_pkg::kpt_t       kpt_rd_data,
    output kp_pkg::kpt_count_t kpt_count
);
    import kp_pkg::*;

    ram_req_t host_req;
    ram_req_t blur_img_req, blur_blr_req;
    ram_req_t det_img_req, det_blr_req;
    ram_req_t img_req, blr_req;
    pixel_t   img_dout, blr_dout;
    logic     blur_go, blur_fin;
    logic     detect_go, detect_fin;
    logic     run_clear;
    logic     kpt_wr;
    kpt_t     kpt_wr_data;

    assign host_req = '{we: img_we, addr: img_addr, din: img_din};

    kp_sequencer seq_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .done         (done),
        .host_req     (host_req),
        .blur_img_req (blur_img_req),
        .blur_blr_req (blur_blr_req),
        .det_img_req  (det_img_req),
        .det_blr_req  (det_blr_req),
        .blur_fin     (blur_fin),
        .detect_fin   (detect_fin),
        .blur_go      (blur_go),
        .detect_go    (detect_go),
        .run_clear    (run_clear),
        .img_req      (img_req),
        .blr_req      (blr_req)
    );

    pixel_ram img_ram (
        .clk  (clk),
        .req  (img_req),
        .dout (img_dout)
    );

    pixel_ram blr_ram (
        .clk  (clk),
        .req  (blr_req),
        .dout (blr_dout)
    );

    blur_engine blur_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .go       (blur_go),
        .fin      (blur_fin),
        .img_req  (blur_img_req),
        .img_dout (img_dout),
        .blr_req  (blur_blr_req)
    );

    keypoint_detect det_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .go          (detect_go),
        .fin         (detect_fin),
        .filter_on   (filter_on),
        .threshold   (threshold),
        .img_req     (det_img_req),
        .blr_req     (det_blr_req),
        .img_dout    (img_dout),
        .blr_dout    (blr_dout),
        .kpt_wr      (kpt_wr),
        .kpt_wr_data (kpt_wr_data)
    );

    keypoint_store store_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .run_clear   (run_clear),
        .kpt_wr      (kpt_wr),
        .kpt_wr_data (kpt_wr_data),
        .kpt_rd_addr (kpt_rd_addr),
        .kpt_rd_data (kpt_rd_data),
        .kpt_count   (kpt_count)
    );

endmodule

//--- kp_macros.svh
`ifndef KP_MACROS_SVH
`define KP_MACROS_SVH

// image geometry
`define KP_IMG_DIM    16
`define KP_PIX_W      8
`define KP_NUM_PIX    256

// keypoint memory entries
`define KP_KPT_DEPTH  256

// 1-2-1 x 1-2-1 kernel sums to 16
`define KP_BLUR_SHIFT 4

`endif

//--- kp_pkg.sv
`include "kp_macros.svh"

package kp_pkg;

    typedef logic [`KP_PIX_W-1:0] pixel_t;
    typedef logic [7:0]           pix_addr_t;   // row * 16 + col
    typedef logic [3:0]           coord_t;
    typedef logic [8:0]           kpt_count_t;  // 0 to 256
    typedef logic [7:0]           thresh_t;

    // one access to a pixel memory
    typedef struct packed {
        logic      we;
        pix_addr_t addr;
        pixel_t    din;
    } ram_req_t;

    typedef struct packed {
        coord_t row;
        coord_t col;
    } kpt_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BLUR,
        ST_DETECT,
        ST_DONE
    } seq_state_t;

endpackage

//--- kp_sequencer.sv
`timescale 1ns/1ps

module kp_sequencer (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    output logic             done,
    input  kp_pkg::ram_req_t host_req,
    input  kp_pkg::ram_req_t blur_img_req,
    input  kp_pkg::ram_req_t blur_blr_req,
    input  kp_pkg::ram_req_t det_img_req,
    input  kp_pkg::ram_req_t det_blr_req,
    input  logic             blur_fin,
    input  logic             detect_fin,
    output logic             blur_go,
    output logic             detect_go,
    output logic             run_clear,
    output kp_pkg::ram_req_t img_req,
    output kp_pkg::ram_req_t blr_req
);
    import kp_pkg::*;

    seq_state_t state, next_state;

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE:   if (start)      next_state = ST_BLUR;
            ST_BLUR:   if (blur_fin)   next_state = ST_DETECT;
            ST_DETECT: if (detect_fin) next_state = ST_DONE;
            ST_DONE:   if (!start)     next_state = ST_IDLE;
            default:                   next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            blur_go   <= 1'b0;
            detect_go <= 1'b0;
            done      <= 1'b0;
        end else begin
            state     <= next_state;
            blur_go   <= (state == ST_IDLE) && start;       // first blur cycle
            detect_go <= (state == ST_BLUR) && blur_fin;
            if (state == ST_DETECT && detect_fin) begin
                done <= 1'b1;
            end else if (state == ST_DONE && !start) begin
                done <= 1'b0;                               // host released start
            end
        end
    end

    assign run_clear = blur_go;  // count restarts with every run

    // memory steering
    always_comb begin
        img_req = '0;
        blr_req = '0;
        case (state)
            ST_IDLE, ST_DONE: begin
                img_req = host_req;
            end
            ST_BLUR: begin
                img_req = blur_img_req;
                blr_req = blur_blr_req;
            end
            ST_DETECT: begin
                img_req = det_img_req;
                blr_req = det_blr_req;
            end
            default: begin
                img_req = '0;
            end
        endcase
    end

    a_done_in_done_state: assert property (
        @(posedge clk) disable iff (!rst_n) done |-> state == ST_DONE
    );

endmodule

//--- pixel_ram.sv
`timescale 1ns/1ps
`include "kp_macros.svh"

module pixel_ram (
    input  logic             clk,
    input  kp_pkg::ram_req_t req,
    output kp_pkg::pixel_t   dout
);
    import kp_pkg::*;

    pixel_t mem [`KP_NUM_PIX];

    always_ff @(posedge clk) begin
        if (req.we) begin
            mem[req.addr] <= req.din;
        end
        dout <= mem[req.addr];  // old data on a write
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the kp_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_kp_core \
    -f sim.f -o sim_kp_core
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_kp_core > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
echo "simulation passed"
exit 0

//--- sim.f
+incdir+.
kp_pkg.sv
pixel_ram.sv
kp_sequencer.sv
blur_engine.sv
keypoint_detect.sv
keypoint_store.sv
kp_core.sv
tb_kp_core.sv

//--- tb_kp_core.sv
`timescale 1ns/1ps
`include "kp_macros.svh"

module tb_kp_core;
    import kp_pkg::*;

    localparam int RUN_LIMIT = 5000;  // blur alone needs about 2300 cycles

    logic       clk;
    logic       rst_n;
    logic       start;
    logic       done;
    logic       img_we;
    pix_addr_t  img_addr;
    pixel_t     img_din;
    logic       filter_on;
    thresh_t    threshold;
    pix_addr_t  kpt_rd_addr;
    kpt_t       kpt_rd_data;
    kpt_count_t kpt_count;

    integer     seed;
    pixel_t     image [`KP_NUM_PIX];
    kpt_t       model_kpts [$];
    int         done_count;
    int         release_cycles;

    kp_core kp_core_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .done        (done),
        .img_we      (img_we),
        .img_addr    (img_addr),
        .img_din     (img_din),
        .filter_on   (filter_on),
        .threshold   (threshold),
        .kpt_rd_addr (kpt_rd_addr),
        .kpt_rd_data (kpt_rd_data),
        .kpt_count   (kpt_count)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // zero outside the image
    function automatic int pixel_at(input int r, input int c);
        if (r < 0 || c < 0 || r >= `KP_IMG_DIM || c >= `KP_IMG_DIM) begin
            return 0;
        end
        return int'(image[r * `KP_IMG_DIM + c]);
    endfunction

    function automatic int blurred_at(input int r, input int c);
        int sum;
        int wr;
        int wc;
        sum = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                wr = (dr == 0) ? 2 : 1;
                wc = (dc == 0) ? 2 : 1;
                sum += wr * wc * pixel_at(r + dr, c + dc);
            end
        end
        return sum / 16;
    endfunction

    task automatic build_model(input bit use_thresh, input int thresh);
        int diff;
        kpt_t k;
        model_kpts.delete();
        for (int r = 0; r < `KP_IMG_DIM; r++) begin
            for (int c = 0; c < `KP_IMG_DIM; c++) begin
                diff = pixel_at(r, c) - blurred_at(r, c);
                if (diff > (use_thresh ? thresh : 0)) begin
                    k.row = coord_t'(r);
                    k.col = coord_t'(c);
                    model_kpts.push_back(k);  // raster order
                end
            end
        end
    endtask

    task automatic load_image();
        for (int a = 0; a < `KP_NUM_PIX; a++) begin
            @(posedge clk);
            #1;
            img_we   = 1'b1;
            img_addr = pix_addr_t'(a);
            img_din  = image[a];
        end
        @(posedge clk);
        #1;
        img_we = 1'b0;
    endtask

    task automatic run_detect(input int hold_cycles);
        int n;
        @(posedge clk);
        #1;
        start = 1'b1;
        n = 0;
        while (!done) begin
            @(posedge clk);
            #1;
            n++;
            if (n > RUN_LIMIT) report_timeout("done did not rise after start");
        end
        done_count = int'(kpt_count);
        for (int i = 0; i < hold_cycles; i++) begin
            @(posedge clk);
            #1;
            check_value("done_held", 1, int'(done));
        end
        start = 1'b0;
        release_cycles = 0;
        while (done) begin
            @(posedge clk);
            #1;
            release_cycles++;
            if (release_cycles > 100) report_timeout("done did not fall after start dropped");
        end
    endtask

    task automatic read_keypoints(input string name);
        check_value({name, "_count"}, model_kpts.size(), done_count);
        for (int i = 0; i < model_kpts.size(); i++) begin
            @(posedge clk);
            #1;
            kpt_rd_addr = pix_addr_t'(i);
            @(posedge clk);
            #1;
            check_value($sformatf("%s_kpt%0d", name, i), int'(model_kpts[i]), int'(kpt_rd_data));
        end
    endtask

    initial begin
        int first_count;
        clk         = 1'b0;
        rst_n       = 1'b0;
        start       = 1'b0;
        img_we      = 1'b0;
        img_addr    = '0;
        img_din     = '0;
        filter_on   = 1'b0;
        threshold   = '0;
        kpt_rd_addr = '0;
        seed        = 72;

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // 1: reset values
        check_value("reset_done", 0, int'(done));
        check_value("reset_count", 0, int'(kpt_count));

        // 2: flat image, nothing beats 255
        for (int a = 0; a < `KP_NUM_PIX; a++) begin
            image[a] = 8'd100;
        end
        load_image();
        filter_on = 1'b1;
        threshold = 8'd255;
        run_detect(0);
        check_value("flat_count", 0, done_count);

        // 3: random image, threshold 20
        for (int a = 0; a < `KP_NUM_PIX; a++) begin
            image[a] = pixel_t'($random(seed));
        end
        load_image();
        threshold = 8'd20;
        build_model(1'b1, 20);
        run_detect(0);
        read_keypoints("random_thresh");

        // 4: filter off compares against zero
        filter_on = 1'b0;
        build_model(1'b0, 20);
        run_detect(0);
        read_keypoints("random_nofilter");

        // 5: handshake and count clearing
        filter_on = 1'b1;
        build_model(1'b1, 20);
        run_detect(25);
        check_value("release_cycles", 1, release_cycles);
        @(posedge clk);
        #1;
        check_value("done_stays_low", 0, int'(done));  // no restart without start
        first_count = done_count;
        run_detect(0);
        check_value("second_run_count", first_count, done_count);
        read_keypoints("second_run");

        $display("TEST OK");
        $finish;
    end

endmodule
